//--- common/dcache_pkg.sv
package dcache_pkg;

    // bank geometry
    localparam int cbanks    = 4;
    localparam int cwidth    = 2;
    localparam int cassoc    = 2;
    localparam int bank_rows = 16;

    localparam int bank_w = $clog2(cbanks);
    localparam int word_w = $clog2(cwidth);
    localparam int way_w  = $clog2(cassoc);
    localparam int row_w  = $clog2(bank_rows);

    // one way of a row, and the whole row across all ways
    localparam int way_bits = cwidth * 32;
    localparam int row_bits = cassoc * way_bits;
    localparam int wm_bits  = row_bits / 8;

    // core byte address: row | bank | word | byte
    localparam int word_lsb    = 2;
    localparam int bank_lsb    = word_lsb + word_w;
    localparam int row_lsb     = bank_lsb + bank_w;
    localparam int core_addr_w = row_lsb + row_w;

    // memory controller row address: way | row | bank
    localparam int memc_bank_lsb = 0;
    localparam int memc_row_lsb  = memc_bank_lsb + bank_w;
    localparam int memc_way_lsb  = memc_row_lsb + row_w;
    localparam int memc_addr_w   = memc_way_lsb + way_w;

    // one bank row, seen flat by the SRAM and per lane by the datapath
    typedef union packed {
        logic [row_bits-1:0] flat;
        logic [cassoc-1:0][cwidth-1:0][31:0] lane;
    } bank_row_u;

endpackage

//--- logic/bank_ram.sv
`timescale 1ns/1ps

module bank_ram (
    input  logic                                   clk,

    input  logic                                   a_ce_n,
    input  logic                                   a_we_n,
    input  logic [dcache_pkg::row_w-1:0]           a_addr,
    input  dcache_pkg::bank_row_u                  a_wdata,
    input  logic [dcache_pkg::wm_bits-1:0]         a_wm,
    output dcache_pkg::bank_row_u                  a_rdata,

    input  logic                                   b_ce_n,
    input  logic                                   b_we_n,
    input  logic [dcache_pkg::row_w-1:0]           b_addr,
    input  dcache_pkg::bank_row_u                  b_wdata,
    input  logic [dcache_pkg::wm_bits-1:0]         b_wm,
    output dcache_pkg::bank_row_u                  b_rdata
);
    import dcache_pkg::*;

    logic [row_bits-1:0] mem [bank_rows];
    logic [row_w-1:0] a_raddr;
    logic [row_w-1:0] b_raddr;

    // byte masked writes, port b last
    always_ff @(posedge clk) begin
        for (int i = 0; i < wm_bits; i++) begin
            if (!a_ce_n && !a_we_n && a_wm[i]) begin
                mem[a_addr][i*8 +: 8] <= a_wdata.flat[i*8 +: 8];
            end
            if (!b_ce_n && !b_we_n && b_wm[i]) begin
                mem[b_addr][i*8 +: 8] <= b_wdata.flat[i*8 +: 8];
            end
        end
    end

    // address stage, then output stage
    always_ff @(posedge clk) begin
        if (!a_ce_n && a_we_n) begin
            a_raddr <= a_addr;
        end
        if (!b_ce_n && b_we_n) begin
            b_raddr <= b_addr;
        end
        a_rdata.flat <= mem[a_raddr];
        b_rdata.flat <= mem[b_raddr];
    end

endmodule

//--- dcache/dcache_port_router.sv
`timescale 1ns/1ps

module dcache_port_router (
    input  logic                                               core_re_n,
    input  logic                                               core_we_n,
    input  logic [dcache_pkg::core_addr_w-1:0]                 core_addr,
    input  logic [dcache_pkg::way_w-1:0]                       core_wassoc,
    input  logic [3:0]                                         core_wmask,
    input  logic [31:0]                                        core_wdata,

    input  logic                                               memc_ce_n,
    input  logic                                               memc_we_n,
    input  logic [dcache_pkg::memc_addr_w-1:0]                 memc_addr,
    input  logic [dcache_pkg::way_bits-1:0]                    memc_wdata,

    output logic                                               busy,
    output logic [dcache_pkg::bank_w-1:0]                      busy_bank,
    output logic                                               core_grant_rd,
    output logic [dcache_pkg::bank_w-1:0]                      core_bank,

    output logic [dcache_pkg::cbanks-1:0]                      bank_ce_n,
    output logic [dcache_pkg::cbanks-1:0]                      bank_we_n,
    output logic [dcache_pkg::cbanks-1:0][dcache_pkg::row_w-1:0] bank_addr,
    output dcache_pkg::bank_row_u [dcache_pkg::cbanks-1:0]     bank_wdata,
    output logic [dcache_pkg::cbanks-1:0][dcache_pkg::wm_bits-1:0] bank_wm
);
    import dcache_pkg::*;

    logic [word_w-1:0] core_word;
    logic [row_w-1:0] core_row;
    logic [row_w-1:0] memc_row;
    logic [way_w-1:0] memc_way;
    logic conflict;
    bank_row_u core_data;
    bank_row_u memc_data;
    logic [wm_bits-1:0] core_wm;
    logic [wm_bits-1:0] memc_wm;

    assign core_word = core_addr[word_lsb +: word_w];
    assign core_bank = core_addr[bank_lsb +: bank_w];
    assign core_row  = core_addr[row_lsb +: row_w];
    assign memc_row  = memc_addr[memc_row_lsb +: row_w];
    assign memc_way  = memc_addr[memc_way_lsb +: way_w];

    // memory controller always owns the bank it addresses
    assign busy          = !memc_ce_n;
    assign busy_bank     = memc_addr[memc_bank_lsb +: bank_w];
    assign conflict      = busy && (busy_bank == core_bank);
    assign core_grant_rd = !core_re_n && core_we_n && !conflict;

    // core word goes to every lane, mask picks the lane
    always_comb begin
        for (int a = 0; a < cassoc; a++) begin
            memc_data.lane[a] = memc_wdata;
            for (int w = 0; w < cwidth; w++) begin
                core_data.lane[a][w] = core_wdata;
                if (a == int'(core_wassoc) && w == int'(core_word)) begin
                    core_wm[(a*cwidth + w)*4 +: 4] = core_wmask;
                end else begin
                    core_wm[(a*cwidth + w)*4 +: 4] = 4'h0;
                end
                if (a == int'(memc_way)) begin
                    memc_wm[(a*cwidth + w)*4 +: 4] = 4'hf;
                end else begin
                    memc_wm[(a*cwidth + w)*4 +: 4] = 4'h0;
                end
            end
        end
    end

    always_comb begin
        for (int b = 0; b < cbanks; b++) begin
            bank_ce_n[b]  = 1'b1;
            bank_we_n[b]  = 1'b1;
            bank_addr[b]  = core_row;
            bank_wdata[b] = core_data;
            bank_wm[b]    = core_wm;
            if (!core_re_n && core_bank == bank_w'(b)) begin
                bank_ce_n[b] = 1'b0;
                bank_we_n[b] = core_we_n;
            end
            // full row of one way, overrides the core
            if (!memc_ce_n && busy_bank == bank_w'(b)) begin
                bank_ce_n[b]  = 1'b0;
                bank_we_n[b]  = memc_we_n;
                bank_addr[b]  = memc_row;
                bank_wdata[b] = memc_data;
                bank_wm[b]    = memc_wm;
            end
        end
    end

endmodule

//--- dcache/dcache_read_select.sv
`timescale 1ns/1ps

module dcache_read_select (
    input  logic                                           clk,
    input  logic                                           rst,

    input  dcache_pkg::bank_row_u [dcache_pkg::cbanks-1:0] a_rdata,
    input  dcache_pkg::bank_row_u [dcache_pkg::cbanks-1:0] b_rdata,

    input  logic                                           core0_grant_rd,
    input  logic [dcache_pkg::bank_w-1:0]                  core0_bank,
    input  logic [dcache_pkg::word_w-1:0]                  core0_word,
    input  logic                                           core1_grant_rd,
    input  logic [dcache_pkg::bank_w-1:0]                  core1_bank,
    input  logic [dcache_pkg::word_w-1:0]                  core1_word,
    input  logic                                           memc_rd_ce_n,
    input  logic [dcache_pkg::memc_addr_w-1:0]             memc_rd_addr,

    output logic [dcache_pkg::cassoc-1:0][31:0]            core0_rdata,
    output logic                                           core0_rvalid,
    output logic [dcache_pkg::cassoc-1:0][31:0]            core1_rdata,
    output logic                                           core1_rvalid,
    output logic [dcache_pkg::way_bits-1:0]                memc_rdata,
    output logic                                           memc_rvalid
);
    import dcache_pkg::*;

    logic [1:0] c0_vld;
    logic [1:0] c1_vld;
    logic [1:0] m_vld;
    logic [1:0][bank_w-1:0] c0_bank_q;
    logic [1:0][bank_w-1:0] c1_bank_q;
    logic [1:0][bank_w-1:0] m_bank_q;
    logic [1:0][word_w-1:0] c0_word_q;
    logic [1:0][word_w-1:0] c1_word_q;
    logic [1:0][way_w-1:0] m_way_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            c0_vld <= '0;
            c1_vld <= '0;
            m_vld  <= '0;
        end else begin
            c0_vld <= {c0_vld[0], core0_grant_rd};
            c1_vld <= {c1_vld[0], core1_grant_rd};
            m_vld  <= {m_vld[0], !memc_rd_ce_n};
        end
    end

    // read tags follow the bank ram pipeline
    always_ff @(posedge clk) begin
        c0_bank_q <= {c0_bank_q[0], core0_bank};
        c0_word_q <= {c0_word_q[0], core0_word};
        c1_bank_q <= {c1_bank_q[0], core1_bank};
        c1_word_q <= {c1_word_q[0], core1_word};
        m_bank_q  <= {m_bank_q[0], memc_rd_addr[memc_bank_lsb +: bank_w]};
        m_way_q   <= {m_way_q[0], memc_rd_addr[memc_way_lsb +: way_w]};
    end

    // core gets one word of every way, memc one way of the row
    always_comb begin
        for (int a = 0; a < cassoc; a++) begin
            core0_rdata[a] = a_rdata[c0_bank_q[1]].lane[a][c0_word_q[1]];
            core1_rdata[a] = b_rdata[c1_bank_q[1]].lane[a][c1_word_q[1]];
        end
        memc_rdata = a_rdata[m_bank_q[1]].lane[m_way_q[1]];
    end

    assign core0_rvalid = c0_vld[1];
    assign core1_rvalid = c1_vld[1];
    assign memc_rvalid  = m_vld[1];

endmodule

//--- dcache/dcache_banks.sv
`timescale 1ns/1ps

module dcache_banks (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                core0_re_n,
    input  logic                                core0_we_n,
    input  logic [dcache_pkg::core_addr_w-1:0]  core0_addr,
    input  logic [dcache_pkg::way_w-1:0]        core0_wassoc,
    input  logic [3:0]                          core0_wmask,
    input  logic [31:0]                         core0_wdata,
    output logic                                core0_busy,
    output logic [dcache_pkg::bank_w-1:0]       core0_busy_bank,
    output logic [dcache_pkg::cassoc-1:0][31:0] core0_rdata,
    output logic                                core0_rvalid,

    input  logic                                core1_re_n,
    input  logic                                core1_we_n,
    input  logic [dcache_pkg::core_addr_w-1:0]  core1_addr,
    input  logic [dcache_pkg::way_w-1:0]        core1_wassoc,
    input  logic [3:0]                          core1_wmask,
    input  logic [31:0]                         core1_wdata,
    output logic                                core1_busy,
    output logic [dcache_pkg::bank_w-1:0]       core1_busy_bank,
    output logic [dcache_pkg::cassoc-1:0][31:0] core1_rdata,
    output logic                                core1_rvalid,

    input  logic                                memc_rd_ce_n,
    input  logic [dcache_pkg::memc_addr_w-1:0]  memc_rd_addr,
    output logic [dcache_pkg::way_bits-1:0]     memc_rdata,
    output logic                                memc_rvalid,

    input  logic                                memc_wr_ce_n,
    input  logic [dcache_pkg::memc_addr_w-1:0]  memc_wr_addr,
    input  logic [dcache_pkg::way_bits-1:0]     memc_wdata
);
    import dcache_pkg::*;

    logic [cbanks-1:0] a_ce_n;
    logic [cbanks-1:0] a_we_n;
    logic [cbanks-1:0][row_w-1:0] a_addr;
    bank_row_u [cbanks-1:0] a_wdata;
    logic [cbanks-1:0][wm_bits-1:0] a_wm;
    bank_row_u [cbanks-1:0] a_rdata;

    logic [cbanks-1:0] b_ce_n;
    logic [cbanks-1:0] b_we_n;
    logic [cbanks-1:0][row_w-1:0] b_addr;
    bank_row_u [cbanks-1:0] b_wdata;
    logic [cbanks-1:0][wm_bits-1:0] b_wm;
    bank_row_u [cbanks-1:0] b_rdata;

    logic core0_grant_rd;
    logic core1_grant_rd;
    logic [bank_w-1:0] core0_bank;
    logic [bank_w-1:0] core1_bank;

    // port a: core 0 and eviction reads
    dcache_port_router u_router_a (
        .core_re_n     (core0_re_n),
        .core_we_n     (core0_we_n),
        .core_addr     (core0_addr),
        .core_wassoc   (core0_wassoc),
        .core_wmask    (core0_wmask),
        .core_wdata    (core0_wdata),
        .memc_ce_n     (memc_rd_ce_n),
        .memc_we_n     (1'b1),
        .memc_addr     (memc_rd_addr),
        .memc_wdata    ('0),
        .busy          (core0_busy),
        .busy_bank     (core0_busy_bank),
        .core_grant_rd (core0_grant_rd),
        .core_bank     (core0_bank),
        .bank_ce_n     (a_ce_n),
        .bank_we_n     (a_we_n),
        .bank_addr     (a_addr),
        .bank_wdata    (a_wdata),
        .bank_wm       (a_wm)
    );

    // port b: core 1 and line fills
    dcache_port_router u_router_b (
        .core_re_n     (core1_re_n),
        .core_we_n     (core1_we_n),
        .core_addr     (core1_addr),
        .core_wassoc   (core1_wassoc),
        .core_wmask    (core1_wmask),
        .core_wdata    (core1_wdata),
        .memc_ce_n     (memc_wr_ce_n),
        .memc_we_n     (1'b0),
        .memc_addr     (memc_wr_addr),
        .memc_wdata    (memc_wdata),
        .busy          (core1_busy),
        .busy_bank     (core1_busy_bank),
        .core_grant_rd (core1_grant_rd),
        .core_bank     (core1_bank),
        .bank_ce_n     (b_ce_n),
        .bank_we_n     (b_we_n),
        .bank_addr     (b_addr),
        .bank_wdata    (b_wdata),
        .bank_wm       (b_wm)
    );

    for (genvar i = 0; i < cbanks; i++) begin : g_bank
        bank_ram u_bank (
            .clk     (clk),
            .a_ce_n  (a_ce_n[i]),
            .a_we_n  (a_we_n[i]),
            .a_addr  (a_addr[i]),
            .a_wdata (a_wdata[i]),
            .a_wm    (a_wm[i]),
            .a_rdata (a_rdata[i]),
            .b_ce_n  (b_ce_n[i]),
            .b_we_n  (b_we_n[i]),
            .b_addr  (b_addr[i]),
            .b_wdata (b_wdata[i]),
            .b_wm    (b_wm[i]),
            .b_rdata (b_rdata[i])
        );
    end

    dcache_read_select u_read_select (
        .clk            (clk),
        .rst            (rst),
        .a_rdata        (a_rdata),
        .b_rdata        (b_rdata),
        .core0_grant_rd (core0_grant_rd),
        .core0_bank     (core0_bank),
        .core0_word     (core0_addr[word_lsb +: word_w]),
        .core1_grant_rd (core1_grant_rd),
        .core1_bank     (core1_bank),
        .core1_word     (core1_addr[word_lsb +: word_w]),
        .memc_rd_ce_n   (memc_rd_ce_n),
        .memc_rd_addr   (memc_rd_addr),
        .core0_rdata    (core0_rdata),
        .core0_rvalid   (core0_rvalid),
        .core1_rdata    (core1_rdata),
        .core1_rvalid   (core1_rvalid),
        .memc_rdata     (memc_rdata),
        .memc_rvalid    (memc_rvalid)
    );

endmodule

//--- bench/dcache_props.sv
`timescale 1ns/1ps

module dcache_props (
    input logic                               clk,
    input logic                               rst,
    input logic                               core0_re_n,
    input logic                               core0_we_n,
    input logic [dcache_pkg::core_addr_w-1:0] core0_addr,
    input logic                               core0_busy,
    input logic [dcache_pkg::bank_w-1:0]      core0_busy_bank,
    input logic                               core0_rvalid,
    input logic                               core1_re_n,
    input logic                               core1_we_n,
    input logic [dcache_pkg::core_addr_w-1:0] core1_addr,
    input logic                               core1_busy,
    input logic [dcache_pkg::bank_w-1:0]      core1_busy_bank,
    input logic                               core1_rvalid,
    input logic                               memc_rd_ce_n,
    input logic                               memc_rvalid
);
    import dcache_pkg::*;

    logic core0_granted;
    logic core1_granted;

    // a read counts unless the memory controller holds its bank
    assign core0_granted = !core0_re_n && core0_we_n &&
        !(core0_busy && core0_busy_bank == core0_addr[bank_lsb +: bank_w]);
    assign core1_granted = !core1_re_n && core1_we_n &&
        !(core1_busy && core1_busy_bank == core1_addr[bank_lsb +: bank_w]);

    core0_read_latency: assert property (@(posedge clk) disable iff (rst)
        core0_rvalid == $past(core0_granted, 2))
        else $error("core0_rvalid does not follow a granted read by 2 cycles");

    core1_read_latency: assert property (@(posedge clk) disable iff (rst)
        core1_rvalid == $past(core1_granted, 2))
        else $error("core1_rvalid does not follow a granted read by 2 cycles");

    memc_read_latency: assert property (@(posedge clk) disable iff (rst)
        memc_rvalid == $past(!memc_rd_ce_n, 2))
        else $error("memc_rvalid does not follow an eviction read by 2 cycles");

    no_rvalid_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !core0_rvalid && !core1_rvalid && !memc_rvalid)
        else $error("rvalid high while reset is held");

endmodule

bind dcache_banks dcache_props props0 (
    .clk             (clk),
    .rst             (rst),
    .core0_re_n      (core0_re_n),
    .core0_we_n      (core0_we_n),
    .core0_addr      (core0_addr),
    .core0_busy      (core0_busy),
    .core0_busy_bank (core0_busy_bank),
    .core0_rvalid    (core0_rvalid),
    .core1_re_n      (core1_re_n),
    .core1_we_n      (core1_we_n),
    .core1_addr      (core1_addr),
    .core1_busy      (core1_busy),
    .core1_busy_bank (core1_busy_bank),
    .core1_rvalid    (core1_rvalid),
    .memc_rd_ce_n    (memc_rd_ce_n),
    .memc_rvalid     (memc_rvalid)
);

//--- bench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int fill_cycles = cbanks * bank_rows * cassoc;
    localparam int random_cycles = 200;
    localparam int total_cycles = 3 + fill_cycles + 40 + random_cycles + 100;

    logic clk;
    logic rst;
    logic core0_re_n;
    logic core0_we_n;
    logic [core_addr_w-1:0] core0_addr;
    logic [way_w-1:0] core0_wassoc;
    logic [3:0] core0_wmask;
    logic [31:0] core0_wdata;
    logic core0_busy;
    logic [bank_w-1:0] core0_busy_bank;
    logic [cassoc-1:0][31:0] core0_rdata;
    logic core0_rvalid;
    logic core1_re_n;
    logic core1_we_n;
    logic [core_addr_w-1:0] core1_addr;
    logic [way_w-1:0] core1_wassoc;
    logic [3:0] core1_wmask;
    logic [31:0] core1_wdata;
    logic core1_busy;
    logic [bank_w-1:0] core1_busy_bank;
    logic [cassoc-1:0][31:0] core1_rdata;
    logic core1_rvalid;
    logic memc_rd_ce_n;
    logic [memc_addr_w-1:0] memc_rd_addr;
    logic [way_bits-1:0] memc_rdata;
    logic memc_rvalid;
    logic memc_wr_ce_n;
    logic [memc_addr_w-1:0] memc_wr_addr;
    logic [way_bits-1:0] memc_wdata;

    // expected contents by bank, row, way and word
    logic [31:0] model [cbanks][bank_rows][cassoc][cwidth];

    dcache_banks dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (total_cycles) @(posedge clk);
        $display("Timeout: tests still running after %0d cycles", total_cycles);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    function automatic logic [core_addr_w-1:0] core_address(input int bank, row, word);
        return {row[3:0], bank[1:0], word[0], 2'b00};
    endfunction

    function automatic logic [memc_addr_w-1:0] memc_address(input int bank, row, way);
        return {way[0], row[3:0], bank[1:0]};
    endfunction

    function automatic logic [31:0] fill_word(input int bank, row, way, word);
        return {8'h5a, 4'(bank), 4'(way), 8'(row), 8'(word)};
    endfunction

    function automatic logic [63:0] model_read(input int bank, row, word);
        return {model[bank][row][1][word], model[bank][row][0][word]};
    endfunction

    function automatic logic [63:0] model_row(input int bank, row, way);
        return {model[bank][row][way][1], model[bank][row][way][0]};
    endfunction

    task automatic model_write(input int bank, row, way, word, input logic [3:0] mask,
                               input logic [31:0] data);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                model[bank][row][way][word][i*8 +: 8] = data[i*8 +: 8];
            end
        end
    endtask

    task automatic drive_idle();
        core0_re_n = 1'b1;
        core0_we_n = 1'b1;
        core1_re_n = 1'b1;
        core1_we_n = 1'b1;
        memc_rd_ce_n = 1'b1;
        memc_wr_ce_n = 1'b1;
    endtask

    task automatic init_inputs();
        drive_idle();
        core0_addr = '0;
        core0_wassoc = '0;
        core0_wmask = '0;
        core0_wdata = '0;
        core1_addr = '0;
        core1_wassoc = '0;
        core1_wmask = '0;
        core1_wdata = '0;
        memc_rd_addr = '0;
        memc_wr_addr = '0;
        memc_wdata = '0;
    endtask

    task automatic core_request(input int port, input bit write, input int bank, row, word, way,
                                input logic [3:0] mask, input logic [31:0] data);
        if (port == 0) begin
            core0_re_n = 1'b0;
            core0_we_n = !write;
            core0_addr = core_address(bank, row, word);
            core0_wassoc = way[0];
            core0_wmask = mask;
            core0_wdata = data;
        end else begin
            core1_re_n = 1'b0;
            core1_we_n = !write;
            core1_addr = core_address(bank, row, word);
            core1_wassoc = way[0];
            core1_wmask = mask;
            core1_wdata = data;
        end
    endtask

    // read data shows up two cycles after the request
    task automatic wait_read_latency();
        @(negedge clk);
        drive_idle();
        @(negedge clk);
    endtask

    task automatic fill_all_rows();
        for (int b = 0; b < cbanks; b++) begin
            for (int r = 0; r < bank_rows; r++) begin
                for (int a = 0; a < cassoc; a++) begin
                    memc_wr_ce_n = 1'b0;
                    memc_wr_addr = memc_address(b, r, a);
                    memc_wdata = {fill_word(b, r, a, 1), fill_word(b, r, a, 0)};
                    model[b][r][a][0] = fill_word(b, r, a, 0);
                    model[b][r][a][1] = fill_word(b, r, a, 1);
                    @(negedge clk);
                end
            end
        end
        memc_wr_ce_n = 1'b1;
    endtask

    task automatic test_reset_state();
        check("reset core0_rvalid", 64'd0, 64'(core0_rvalid));
        check("reset core1_rvalid", 64'd0, 64'(core1_rvalid));
        check("reset memc_rvalid", 64'd0, 64'(memc_rvalid));
        check("reset core0_busy", 64'd0, 64'(core0_busy));
        check("reset core1_busy", 64'd0, 64'(core1_busy));
    endtask

    task automatic test_write_read();
        logic [31:0] data;
        data = $urandom;
        core_request(0, 1'b1, 2, 5, 1, 1, 4'hf, data);
        model_write(2, 5, 1, 1, 4'hf, data);
        @(negedge clk);
        core_request(0, 1'b0, 2, 5, 1, 0, 4'h0, 32'h0);
        wait_read_latency();
        check("write_read valid", 64'd1, 64'(core0_rvalid));
        check("write_read data", model_read(2, 5, 1), core0_rdata);
        check("write_read way", 64'(data), 64'(core0_rdata[1]));
    endtask

    task automatic test_byte_mask();
        logic [31:0] data;
        // every byte differs from the old word
        data = ~model[1][9][0][0];
        core_request(1, 1'b1, 1, 9, 0, 0, 4'b0101, data);
        model_write(1, 9, 0, 0, 4'b0101, data);
        @(negedge clk);
        core_request(1, 1'b0, 1, 9, 0, 0, 4'h0, 32'h0);
        @(negedge clk);
        core_request(1, 1'b0, 1, 9, 1, 0, 4'h0, 32'h0);
        @(negedge clk);
        drive_idle();
        check("byte_mask valid", 64'd1, 64'(core1_rvalid));
        check("byte_mask data", model_read(1, 9, 0), core1_rdata);
        @(negedge clk);
        check("byte_mask other word valid", 64'd1, 64'(core1_rvalid));
        check("byte_mask other word", model_read(1, 9, 1), core1_rdata);
    endtask

    task automatic test_line_fill();
        logic [63:0] line;
        line = {$urandom, $urandom};
        memc_wr_ce_n = 1'b0;
        memc_wr_addr = memc_address(3, 12, 1);
        memc_wdata = line;
        model[3][12][1][0] = line[31:0];
        model[3][12][1][1] = line[63:32];
        #1;
        check("line_fill busy", 64'd1, 64'(core1_busy));
        check("line_fill busy_bank", 64'd3, 64'(core1_busy_bank));
        @(negedge clk);
        memc_wr_ce_n = 1'b1;
        core_request(1, 1'b0, 3, 12, 0, 0, 4'h0, 32'h0);
        @(negedge clk);
        core_request(1, 1'b0, 3, 12, 1, 0, 4'h0, 32'h0);
        @(negedge clk);
        drive_idle();
        check("line_fill word0 valid", 64'd1, 64'(core1_rvalid));
        check("line_fill word0", model_read(3, 12, 0), core1_rdata);
        @(negedge clk);
        check("line_fill word1 valid", 64'd1, 64'(core1_rvalid));
        check("line_fill word1", model_read(3, 12, 1), core1_rdata);
        memc_rd_ce_n = 1'b0;
        memc_rd_addr = memc_address(3, 12, 1);
        wait_read_latency();
        check("line_fill evict valid", 64'd1, 64'(memc_rvalid));
        check("line_fill evict data", line, memc_rdata);
    endtask

    task automatic test_bank_conflict();
        // eviction read and core 0 read hit bank 2 together
        memc_rd_ce_n = 1'b0;
        memc_rd_addr = memc_address(2, 3, 0);
        core_request(0, 1'b0, 2, 7, 0, 0, 4'h0, 32'h0);
        #1;
        check("conflict busy", 64'd1, 64'(core0_busy));
        check("conflict busy_bank", 64'd2, 64'(core0_busy_bank));
        wait_read_latency();
        check("conflict core valid", 64'd0, 64'(core0_rvalid));
        check("conflict memc valid", 64'd1, 64'(memc_rvalid));
        check("conflict memc data", model_row(2, 3, 0), memc_rdata);
        // denied write must leave the row alone
        memc_rd_ce_n = 1'b0;
        memc_rd_addr = memc_address(2, 3, 1);
        core_request(0, 1'b1, 2, 3, 0, 0, 4'hf, ~model[2][3][0][0]);
        wait_read_latency();
        check("conflict memc way1", model_row(2, 3, 1), memc_rdata);
        memc_rd_ce_n = 1'b0;
        memc_rd_addr = memc_address(2, 3, 0);
        core_request(0, 1'b0, 1, 4, 1, 0, 4'h0, 32'h0);
        wait_read_latency();
        check("other bank valid", 64'd1, 64'(core0_rvalid));
        check("other bank data", model_read(1, 4, 1), core0_rdata);
        check("denied write row", model_row(2, 3, 0), memc_rdata);
    endtask

    task automatic check_response(input string name, input logic [64:0] entry,
                                  input logic valid, input logic [63:0] rdata);
        check({name, " valid"}, 64'(entry[64]), 64'(valid));
        if (entry[64]) begin
            check({name, " data"}, entry[63:0], rdata);
        end
    endtask

    task automatic test_random_traffic();
        logic [64:0] q0[$];
        logic [64:0] q1[$];
        int banks[2];
        int row;
        int word;
        int way;
        bit write;
        logic [3:0] mask;
        logic [31:0] data;
        for (int i = 0; i < random_cycles + 2; i++) begin
            if (i >= 2) begin
                check_response("random core0", q0.pop_front(), core0_rvalid, core0_rdata);
                check_response("random core1", q1.pop_front(), core1_rvalid, core1_rdata);
            end
            if (i < random_cycles) begin
                banks[0] = $urandom % cbanks;
                banks[1] = (banks[0] + 1 + $urandom % (cbanks - 1)) % cbanks;
                for (int p = 0; p < 2; p++) begin
                    row = $urandom % bank_rows;
                    word = $urandom % cwidth;
                    way = $urandom % cassoc;
                    write = ($urandom % 2) == 1;
                    mask = 4'($urandom);
                    data = $urandom;
                    core_request(p, write, banks[p], row, word, way, mask, data);
                    if (write) begin
                        model_write(banks[p], row, way, word, mask, data);
                    end
                    if (p == 0) begin
                        q0.push_back({!write, write ? 64'd0 : model_read(banks[p], row, word)});
                    end else begin
                        q1.push_back({!write, write ? 64'd0 : model_read(banks[p], row, word)});
                    end
                end
            end else begin
                drive_idle();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        void'($urandom(32'h7fb9));
        rst = 1'b1;
        init_inputs();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        fill_all_rows();
        test_write_read();
        test_byte_mask();
        test_line_fill();
        test_bank_conflict();
        test_random_traffic();
        $display("No errors");
        $finish;
    end

endmodule

//--- filelist.f
common/dcache_pkg.sv
logic/bank_ram.sv
dcache/dcache_port_router.sv
dcache/dcache_read_select.sv
dcache/dcache_banks.sv
bench/dcache_props.sv
bench/dcache_tb.sv

//--- Makefile
# Verilator build and run of the banked data cache testbench

TOP := dcache_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
